// ==== list.f ====
logic/minicpu_pkg.sv
logic/cpu_sequencer.sv
logic/mem_wait_timer.sv
logic/core_memory.sv
logic/cpu_datapath.sv
logic/minicpu_top.sv
verification/minicpu_tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert
TOP       = minicpu_tb
FILE_LIST = list.f
OBJ_DIR   = obj_dir
PASS_TEXT = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/minicpu_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench of the minicomputer; drives the front panel through a
// table of small programs plus deposit, examine and step sequences
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module minicpu_tb
  import minicpu_pkg::*;
();

  localparam int NUM_TESTS   = 6;
  localparam int DRIVE_DELAY = 2;
  // Two directed sections are counted like table rows
  localparam int CYCLE_LIMIT = (NUM_TESTS + 2) * (8 * 8 + 16 * 20) + 100;

  localparam word_t DEPOSIT_PATTERN [4] = '{12'o1357, 12'o6420, 12'o7777, 12'o0001};
  // TAD 1104 twice, halt, spare word, operand
  localparam word_t STEP_PROGRAM [5] = '{12'o1304, 12'o1304, 12'o7402, 12'o0000, 12'o0011};

  typedef struct packed {
    word_t       start;
    logic [3:0]  length;
    word_t [0:7] prog;
    word_t       opnd_addr;
    word_t       opnd_value;
    disp_sel_e   disp;                          // Display selection during the run
    word_t       ac_init;
    word_t       exp_ac;
    word_t       exp_pc;
    word_t       check_addr;
    word_t       exp_word;
  } test_row_t;

  typedef enum {KEY_STEP, KEY_SRCHANGE, KEY_LOADPC, KEY_LOADAC, KEY_DEPOSIT} panel_key_e;

  logic      clock;
  logic      resetN;
  logic      run;
  logic      step;
  logic      loadpc;
  logic      loadac;
  logic      deposit;
  logic      srchange;
  word_t     switch_reg;
  disp_sel_e dispsel;
  word_t     display;
  logic      cpu_idle;
  logic      halt;

  test_row_t rows [NUM_TESTS];
  string     names [NUM_TESTS];
  int        cycles;

  minicpu_top dut0 (
    .clock, .resetN, .run, .step, .loadpc, .loadac, .deposit, .srchange,
    .switch_reg, .dispsel, .display, .cpu_idle, .halt
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic stop_run(string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(string name, word_t expected, word_t actual);
    if (actual !== expected)
      stop_run($sformatf("MISMATCH %s expected %04o actual %04o", name, expected, actual));
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    if (actual !== expected)
      stop_run($sformatf("MISMATCH %s expected %b actual %b", name, expected, actual));
  endtask

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clock);
      cycles++;
    end
    stop_run($sformatf("Timeout: tests did not finish within %0d clock cycles", cycles));
  end

  task automatic tick();
    @(posedge clock);
    #DRIVE_DELAY;
  endtask

  // HALT_ST also shows cpu_idle but ignores panel keys
  task automatic wait_ready();
    while (!(cpu_idle === 1'b1 && halt === 1'b0))
      tick();
  endtask

  task automatic set_key(panel_key_e key, logic level);
    case (key)
      KEY_STEP:     step     = level;
      KEY_SRCHANGE: srchange = level;
      KEY_LOADPC:   loadpc   = level;
      KEY_LOADAC:   loadac   = level;
      default:      deposit  = level;
    endcase
  endtask

  task automatic press_key(panel_key_e key);
    wait_ready();
    set_key(key, 1'b1);
    tick();
    set_key(key, 1'b0);
    wait_ready();
  endtask

  // A single step ends idle without passing through the halt state
  task automatic step_instruction(string name);
    wait_ready();
    set_key(KEY_STEP, 1'b1);
    tick();
    set_key(KEY_STEP, 1'b0);
    while (cpu_idle !== 1'b1)
      tick();
    check_flag({name, " halt"}, 1'b0, halt);
  endtask

  task automatic load_pc(word_t value);
    switch_reg = value;
    press_key(KEY_LOADPC);
  endtask

  task automatic load_ac(word_t value);
    switch_reg = value;
    press_key(KEY_LOADAC);
  endtask

  task automatic deposit_word(word_t value);
    switch_reg = value;
    press_key(KEY_DEPOSIT);
  endtask

  // Display register follows the selection on the next idle edge
  task automatic read_display(disp_sel_e sel, output word_t value);
    wait_ready();
    dispsel = sel;
    tick();
    value = display;
  endtask

  task automatic examine(word_t addr, output word_t value);
    switch_reg = addr;
    press_key(KEY_SRCHANGE);
    read_display(DISP_MB, value);
  endtask

  task automatic run_until_halt(string name);
    wait_ready();
    run = 1'b1;
    tick();
    while (halt !== 1'b1)
      tick();
    run = 1'b0;                                 // Released before the next idle cycle
    check_flag({name, " idle at halt"}, 1'b1, cpu_idle);
    tick();
    check_flag({name, " halt pulse"}, 1'b0, halt);
  endtask

  task automatic build_table();
    names[0] = "tad_dca_after_loadac";
    rows[0]  = '{start: 12'o0200, length: 4'd3,
                 prog: {12'o1250, 12'o3251, 12'o7402, 12'o0000,
                        12'o0000, 12'o0000, 12'o0000, 12'o0000},
                 opnd_addr: 12'o0250, opnd_value: 12'o0023, disp: DISP_AC,
                 ac_init: 12'o7770, exp_ac: 12'o0000, exp_pc: 12'o0203,
                 check_addr: 12'o0251, exp_word: 12'o0013};
    names[1] = "and_then_tad";
    rows[1]  = '{start: 12'o0300, length: 4'd4,
                 prog: {12'o0340, 12'o1303, 12'o7402, 12'o3001,
                        12'o0000, 12'o0000, 12'o0000, 12'o0000},
                 opnd_addr: 12'o0340, opnd_value: 12'o5252, disp: DISP_PC,
                 ac_init: 12'o7777, exp_ac: 12'o0253, exp_pc: 12'o0303,
                 check_addr: 12'o0340, exp_word: 12'o5252};
    names[2] = "isz_wrap_skips";
    rows[2]  = '{start: 12'o0200, length: 4'd5,
                 prog: {12'o2260, 12'o5204, 12'o7402, 12'o7402,
                        12'o7402, 12'o0000, 12'o0000, 12'o0000},
                 opnd_addr: 12'o0260, opnd_value: 12'o7777, disp: DISP_MB,
                 ac_init: 12'o0123, exp_ac: 12'o0123, exp_pc: 12'o0203,
                 check_addr: 12'o0260, exp_word: 12'o0000};
    names[3] = "isz_no_skip_jmp";
    rows[3]  = '{start: 12'o0200, length: 4'd5,
                 prog: {12'o2260, 12'o5204, 12'o7402, 12'o7402,
                        12'o7402, 12'o0000, 12'o0000, 12'o0000},
                 opnd_addr: 12'o0260, opnd_value: 12'o0041, disp: DISP_PC,
                 ac_init: 12'o0456, exp_ac: 12'o0456, exp_pc: 12'o0205,
                 check_addr: 12'o0260, exp_word: 12'o0042};
    names[4] = "jms_current_page";
    rows[4]  = '{start: 12'o0200, length: 4'd7,
                 prog: {12'o4204, 12'o7402, 12'o7402, 12'o7402,
                        12'o0000, 12'o1207, 12'o5201, 12'o0000},
                 opnd_addr: 12'o0207, opnd_value: 12'o0005, disp: DISP_AC,
                 ac_init: 12'o0010, exp_ac: 12'o0015, exp_pc: 12'o0202,
                 check_addr: 12'o0204, exp_word: 12'o0201};
    names[5] = "page_zero_from_page_3";
    rows[5]  = '{start: 12'o0600, length: 4'd5,
                 prog: {12'o1020, 12'o3021, 12'o1204, 12'o7402,
                        12'o0100, 12'o0000, 12'o0000, 12'o0000},
                 opnd_addr: 12'o0020, opnd_value: 12'o1234, disp: DISP_PC,
                 ac_init: 12'o0001, exp_ac: 12'o0100, exp_pc: 12'o0604,
                 check_addr: 12'o0021, exp_word: 12'o1235};
  endtask

  task automatic run_row(int t);
    test_row_t row;
    word_t     value;
    row = rows[t];
    load_pc(row.start);
    for (int k = 0; k < int'(row.length); k++)
      deposit_word(row.prog[k]);
    load_pc(row.opnd_addr);
    deposit_word(row.opnd_value);
    load_ac(row.ac_init);
    read_display(DISP_AC, value);
    check_word({names[t], " loadac"}, row.ac_init, value);
    load_pc(row.start);
    dispsel = row.disp;
    run_until_halt(names[t]);
    read_display(DISP_AC, value);
    check_word({names[t], " ac"}, row.exp_ac, value);
    read_display(DISP_PC, value);
    check_word({names[t], " pc"}, row.exp_pc, value);
    examine(row.check_addr, value);
    check_word({names[t], " memory"}, row.exp_word, value);
  endtask

  initial begin
    word_t value;
    resetN      = 1'b0;
    run         = 1'b0;
    step        = 1'b0;
    loadpc      = 1'b0;
    loadac      = 1'b0;
    deposit     = 1'b0;
    srchange    = 1'b0;
    switch_reg  = '0;
    dispsel     = DISP_PC;
    build_table();
    repeat (2) @(posedge clock);
    #DRIVE_DELAY resetN = 1'b1;
    tick();
    check_flag("reset idle", 1'b1, cpu_idle);
    check_flag("reset halt", 1'b0, halt);

    load_pc(12'o1000);
    for (int i = 0; i < 4; i++) begin
      deposit_word(DEPOSIT_PATTERN[i]);
      read_display(DISP_PC, value);
      check_word("deposit pc advance", word_t'(12'o1001 + i), value);
    end
    for (int i = 0; i < 4; i++) begin
      examine(word_t'(12'o1000 + i), value);
      check_word("examine deposited word", DEPOSIT_PATTERN[i], value);
    end

    for (int t = 0; t < NUM_TESTS; t++)
      run_row(t);

    load_pc(12'o1100);
    for (int i = 0; i < 5; i++)
      deposit_word(STEP_PROGRAM[i]);
    load_ac(12'o0000);
    load_pc(12'o1100);
    for (int s = 1; s <= 2; s++) begin
      step_instruction("step");                 // One instruction per key press
      read_display(DISP_PC, value);
      check_word("step pc", word_t'(12'o1100 + s), value);
    end
    read_display(DISP_AC, value);
    check_word("step ac", 12'o0022, value);

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/minicpu_top.sv ====
//////////////////////////////////////////////////////////////////////
// Minicomputer top level; connects sequencer, wait timer, datapath
// and core memory to the front panel switches and display
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module minicpu_top
  import minicpu_pkg::*;
(
  input  logic      clock,
  input  logic      resetN,
  input  logic      run,
  input  logic      step,
  input  logic      loadpc,
  input  logic      loadac,
  input  logic      deposit,
  input  logic      srchange,
  input  word_t     switch_reg,
  input  disp_sel_e dispsel,
  output word_t     display,
  output logic      cpu_idle,
  output logic      halt
);

  ctrl_t    ctrl;
  status_t  status;
  mem_req_t mem_req;
  word_t    address;
  word_t    write_data;
  word_t    read_data;
  logic     read_enable;
  logic     write_enable;
  logic     mem_finished;

  assign mem_req = '{address: address, write_data: write_data,
                     read_enable: read_enable, write_enable: write_enable};

  cpu_sequencer seq0 (
    .clock, .resetN, .run, .step, .loadpc, .loadac, .deposit, .srchange,
    .mem_finished, .status, .ctrl, .read_enable, .write_enable,
    .cpu_idle, .halt
  );

  mem_wait_timer timer0 (.clock, .resetN, .mem_req, .mem_finished);

  core_memory mem0 (.clock, .mem_req, .mem_finished, .read_data);

  cpu_datapath dp0 (
    .clock, .resetN, .ctrl, .switch_reg, .dispsel, .read_data,
    .status, .address, .write_data, .display
  );

endmodule

`default_nettype wire

// ==== logic/cpu_datapath.sv ====
//////////////////////////////////////////////////////////////////////
// Register file of the CPU; each ctrl action updates its register at
// the next clock edge, IR and MB are reported back to the sequencer
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module cpu_datapath
  import minicpu_pkg::*;
(
  input  logic      clock,
  input  logic      resetN,
  input  ctrl_t     ctrl,
  input  word_t     switch_reg,
  input  disp_sel_e dispsel,
  input  word_t     read_data,
  output status_t   status,
  output word_t     address,
  output word_t     write_data,
  output word_t     display
);

  word_t ac;
  word_t pc;
  word_t ir;
  word_t mb;
  word_t ea;

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN) begin
      ac <= '0;
      pc <= '0;
      ir <= '0;
      mb <= '0;
      ea <= '0;
    end else begin
      case (ctrl.ac_op)
        AC_CLEAR: ac <= '0;
        AC_AND:   ac <= ac & mb;
        AC_TAD:   ac <= ac + mb;                // No link, wraps at 12 bits
        AC_SWREG: ac <= switch_reg;
        default:  ;
      endcase
      case (ctrl.pc_op)
        PC_P1:   pc <= pc + 1'b1;
        PC_SR:   pc <= switch_reg;
        PC_EA:   pc <= ea;
        PC_EAP1: pc <= ea + 1'b1;
        default: ;
      endcase
      if (ctrl.ir_load)
        ir <= read_data;
      case (ctrl.mb_op)
        MB_RD:   mb <= read_data;
        MB_INC:  mb <= mb + 1'b1;
        MB_WD:   mb <= write_data;
        default: ;
      endcase
      case (ctrl.ea_op)
        EA_ZERO_PAGE: ea <= word_t'(ir[PAGE_BITS-1:0]);
        EA_CUR_PAGE:  ea <= {pc[WORD_BITS-1:PAGE_BITS], ir[PAGE_BITS-1:0]};
        default:      ;
      endcase
    end
  end

  // Memory address, write data and panel display hold until reloaded
  always_ff @(posedge clock) begin
    case (ctrl.ad_sel)
      AD_PC:   address <= pc;
      AD_SR:   address <= switch_reg;
      AD_EA:   address <= ea;
      default: ;
    endcase
    case (ctrl.wd_sel)
      WD_SR:   write_data <= switch_reg;
      WD_AC:   write_data <= ac;
      WD_MB:   write_data <= mb;
      WD_PC:   write_data <= pc;
      default: ;
    endcase
    if (ctrl.disp_load) begin
      case (dispsel)
        DISP_AC: display <= ac;
        DISP_MB: display <= mb;
        default: display <= pc;
      endcase
    end
  end

  assign status.ir = ir;
  assign status.mb = mb;

endmodule

`default_nettype wire

// ==== logic/core_memory.sv ====
//////////////////////////////////////////////////////////////////////
// Word-addressed core store; combinational read, write committed at
// the edge that closes the finished cycle of a write access
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module core_memory
  import minicpu_pkg::*;
(
  input  logic     clock,
  input  mem_req_t mem_req,
  input  logic     mem_finished,
  output word_t    read_data
);

  word_t mem [MEM_WORDS];
  logic  active;

  assign active = mem_req.read_enable || mem_req.write_enable;

  always_ff @(posedge clock) begin
    if (mem_req.write_enable && mem_finished)
      mem[mem_req.address] <= mem_req.write_data;
  end

  assign read_data = mem[mem_req.address];

  // Datapath holds the address register for the whole access
  a_address_stable: assert property (@(posedge clock)
    (active && $past(active)) |-> $stable(mem_req.address));

endmodule

`default_nettype wire

// ==== logic/mem_wait_timer.sv ====
//////////////////////////////////////////////////////////////////////
// Models the core memory cycle time; mem_finished marks the last
// cycle of each read or write access
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module mem_wait_timer
  import minicpu_pkg::*;
(
  input  logic     clock,
  input  logic     resetN,
  input  mem_req_t mem_req,
  output logic     mem_finished
);

  logic                 active;
  logic [WAIT_BITS-1:0] count;

  assign active = mem_req.read_enable || mem_req.write_enable;

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN)
      count <= WAIT_BITS'(MEM_WAIT);
    else if (!active)
      count <= WAIT_BITS'(MEM_WAIT);            // Rearm between accesses
    else
      count <= count - 1'b1;
  end

  assign mem_finished = active && (count == WAIT_BITS'(1));

  // An access keeps its enable until the timer finishes it
  a_enable_held: assert property (@(posedge clock) disable iff (!resetN)
    (active && !mem_finished) |=> active);

endmodule

`default_nettype wire

// ==== logic/cpu_sequencer.sv ====
//////////////////////////////////////////////////////////////////////
// Moore FSM that turns panel commands and fetched instructions into
// datapath actions and core memory read and write enables
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module cpu_sequencer
  import minicpu_pkg::*;
(
  input  logic    clock,
  input  logic    resetN,
  input  logic    run,
  input  logic    step,
  input  logic    loadpc,
  input  logic    loadac,
  input  logic    deposit,
  input  logic    srchange,
  input  logic    mem_finished,
  input  status_t status,
  output ctrl_t   ctrl,
  output logic    read_enable,
  output logic    write_enable,
  output logic    cpu_idle,
  output logic    halt
);

  typedef enum logic [4:0] {
    INIT, IDLE, EXAM_1, EXAM_2, LD_PC, LD_AC, DEP_1, DEP_2,
    FETCH_1, FETCH_2, FETCH_3, DECODE, CALC_EA,
    AND_1, AND_2, AND_3, TAD_1, TAD_2, TAD_3,
    ISZ_1, ISZ_2, ISZ_3, ISZ_4, ISZ_5, ISZ_6,
    DCA_1, DCA_2, DCA_3, JMS_1, JMS_2, JMP_1, HALT_ST
  } state_e;

  typedef enum logic [2:0] {
    OP_AND, OP_TAD, OP_ISZ, OP_DCA, OP_JMS, OP_JMP, OP_IOT, OP_OPR
  } opcode_e;

  state_e  state;
  state_e  next_state;
  opcode_e opcode;

  assign opcode = opcode_e'(status.ir[11:9]);

  always_ff @(posedge clock, negedge resetN) begin
    if (!resetN)
      state <= INIT;
    else
      state <= next_state;
  end

  always_comb begin
    next_state = state;
    unique case (state)
      INIT:    next_state = IDLE;
      IDLE: begin
        if (run || step)
          next_state = FETCH_1;
        else if (srchange)
          next_state = EXAM_1;
        else if (loadpc)
          next_state = LD_PC;
        else if (loadac)
          next_state = LD_AC;
        else if (deposit)
          next_state = DEP_1;
      end
      EXAM_1:  next_state = EXAM_2;
      EXAM_2:  if (mem_finished) next_state = IDLE;
      LD_PC:   next_state = IDLE;
      LD_AC:   next_state = IDLE;
      DEP_1:   next_state = DEP_2;
      DEP_2:   if (mem_finished) next_state = IDLE;
      FETCH_1: next_state = FETCH_2;
      FETCH_2: if (mem_finished) next_state = FETCH_3;
      FETCH_3: next_state = DECODE;
      DECODE: begin
        if (status.ir == HALT_WORD)
          next_state = HALT_ST;
        else if (opcode == OP_IOT || opcode == OP_OPR)
          next_state = IDLE;                    // Treated as no-ops
        else
          next_state = CALC_EA;
      end
      CALC_EA: begin
        case (opcode)
          OP_AND:  next_state = AND_1;
          OP_TAD:  next_state = TAD_1;
          OP_ISZ:  next_state = ISZ_1;
          OP_DCA:  next_state = DCA_1;
          OP_JMS:  next_state = JMS_1;
          default: next_state = JMP_1;
        endcase
      end
      AND_1:   next_state = AND_2;
      AND_2:   if (mem_finished) next_state = AND_3;
      AND_3:   next_state = IDLE;
      TAD_1:   next_state = TAD_2;
      TAD_2:   if (mem_finished) next_state = TAD_3;
      TAD_3:   next_state = IDLE;
      ISZ_1:   next_state = ISZ_2;
      ISZ_2:   if (mem_finished) next_state = ISZ_3;
      ISZ_3:   next_state = ISZ_4;
      ISZ_4:   next_state = ISZ_5;
      ISZ_5:   if (mem_finished) next_state = ISZ_6;
      ISZ_6:   next_state = IDLE;
      DCA_1:   next_state = DCA_2;
      DCA_2:   if (mem_finished) next_state = DCA_3;
      DCA_3:   next_state = IDLE;
      JMS_1:   next_state = JMS_2;
      JMS_2:   if (mem_finished) next_state = IDLE;
      JMP_1:   next_state = IDLE;
      HALT_ST: next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  always_comb begin
    ctrl         = '0;                          // All actions NC
    read_enable  = 1'b0;
    write_enable = 1'b0;
    cpu_idle     = 1'b0;
    halt         = 1'b0;
    unique case (state)
      INIT:    ctrl.ac_op = AC_CLEAR;
      IDLE: begin
        cpu_idle       = 1'b1;
        ctrl.disp_load = 1'b1;
      end
      EXAM_1:  ctrl.ad_sel = AD_SR;
      EXAM_2: begin
        read_enable = 1'b1;
        ctrl.mb_op  = MB_RD;
      end
      LD_PC:   ctrl.pc_op = PC_SR;
      LD_AC:   ctrl.ac_op = AC_SWREG;
      DEP_1: begin
        ctrl.ad_sel = AD_PC;
        ctrl.wd_sel = WD_SR;
      end
      DEP_2: begin
        write_enable = 1'b1;
        if (mem_finished)
          ctrl.pc_op = PC_P1;                   // Advance to next deposit slot
      end
      FETCH_1: ctrl.ad_sel = AD_PC;
      FETCH_2: read_enable = 1'b1;
      FETCH_3: begin
        ctrl.ir_load = 1'b1;                    // Address still holds the PC
        ctrl.pc_op   = PC_P1;
      end
      DECODE:  ;
      CALC_EA: ctrl.ea_op = status.ir[7] ? EA_CUR_PAGE : EA_ZERO_PAGE;
      AND_1, TAD_1, ISZ_1: ctrl.ad_sel = AD_EA;
      AND_2, TAD_2, ISZ_2: begin
        read_enable = 1'b1;
        ctrl.mb_op  = MB_RD;
      end
      AND_3:   ctrl.ac_op = AC_AND;
      TAD_3:   ctrl.ac_op = AC_TAD;
      ISZ_3:   ctrl.mb_op = MB_INC;
      ISZ_4:   ctrl.wd_sel = WD_MB;
      ISZ_5:   write_enable = 1'b1;
      ISZ_6:   if (status.mb == '0) ctrl.pc_op = PC_P1;  // Skip on wrap to zero
      DCA_1: begin
        ctrl.ad_sel = AD_EA;
        ctrl.wd_sel = WD_AC;
      end
      DCA_2: begin
        write_enable = 1'b1;
        ctrl.mb_op   = MB_WD;
      end
      DCA_3:   ctrl.ac_op = AC_CLEAR;
      JMS_1: begin
        ctrl.ad_sel = AD_EA;
        ctrl.wd_sel = WD_PC;                    // Return address
      end
      JMS_2: begin
        write_enable = 1'b1;
        ctrl.mb_op   = MB_WD;
        ctrl.pc_op   = PC_EAP1;
      end
      JMP_1:   ctrl.pc_op = PC_EA;
      HALT_ST: begin
        halt           = 1'b1;
        cpu_idle       = 1'b1;
        ctrl.disp_load = 1'b1;
      end
      default: ;
    endcase
  end

  a_one_enable: assert property (@(posedge clock) disable iff (!resetN)
    !(read_enable && write_enable));

  // Every access must end the cycle after the timer reports completion
  a_drop_after_finished: assert property (@(posedge clock) disable iff (!resetN)
    mem_finished |=> !(read_enable || write_enable));

  // Only direct addressing is implemented
  a_direct_only: assert property (@(posedge clock) disable iff (!resetN)
    (state == CALC_EA) |-> !status.ir[8]);

endmodule

`default_nettype wire

// ==== logic/minicpu_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared word type, sizes, control enums and bus structs of the
// minicomputer; imported by every design unit and the testbench
//////////////////////////////////////////////////////////////////////
`default_nettype none

package minicpu_pkg;

  localparam int WORD_BITS = 12;
  localparam int MEM_WORDS = 4096;
  localparam int MEM_WAIT  = 3;                 // Cycles per core access
  localparam int WAIT_BITS = $clog2(MEM_WAIT + 1);
  localparam int PAGE_BITS = 7;                 // Offset width within a page

  typedef logic [WORD_BITS-1:0] word_t;

  localparam word_t HALT_WORD = 12'o7402;       // HLT microinstruction

  typedef enum logic [2:0] {
    AC_NC, AC_CLEAR, AC_AND, AC_TAD, AC_SWREG
  } ac_op_e;

  typedef enum logic [2:0] {
    PC_NC, PC_P1, PC_SR, PC_EA, PC_EAP1
  } pc_op_e;

  typedef enum logic [1:0] {
    MB_NC, MB_RD, MB_INC, MB_WD
  } mb_op_e;

  typedef enum logic [1:0] {
    EA_NC, EA_ZERO_PAGE, EA_CUR_PAGE
  } ea_op_e;

  typedef enum logic [1:0] {
    AD_NC, AD_PC, AD_SR, AD_EA
  } ad_sel_e;

  typedef enum logic [2:0] {
    WD_NC, WD_SR, WD_AC, WD_MB, WD_PC
  } wd_sel_e;

  typedef enum logic [1:0] {
    DISP_PC, DISP_AC, DISP_MB
  } disp_sel_e;

  // Sequencer to datapath
  typedef struct packed {
    ac_op_e  ac_op;
    pc_op_e  pc_op;
    mb_op_e  mb_op;
    ea_op_e  ea_op;
    ad_sel_e ad_sel;
    wd_sel_e wd_sel;
    logic    ir_load;
    logic    disp_load;
  } ctrl_t;

  // Datapath back to sequencer
  typedef struct packed {
    word_t ir;
    word_t mb;
  } status_t;

  typedef struct packed {
    word_t address;
    word_t write_data;
    logic  read_enable;
    logic  write_enable;
  } mem_req_t;

endpackage

`default_nettype wire
